/* rtl/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define OP_W        6      // Unit code plus variant

// Instruction field widths and positions
`define OPCODE_W    7
`define FUNCT3_W    3
`define FUNCT7_W    7
`define SIGN_BIT    31     // Sign of every immediate
`define FUNCT7_ALT  7'b0100000   // SUB and SRA/SRAI select

// Base opcodes, RV32I
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_IMM       7'b0010011
`define OPC_OP        7'b0110011
`define OPC_MISC_MEM  7'b0001111

`endif

/* rtl/decode_pkg.sv */
`include "decode_macros.svh"

package decode_pkg;

    ////////////////////
    // Execution units
    ////////////////////

    // Upper three bits of every operation code
    typedef enum logic [2:0] {
        ALU_UNIT    = 3'b000,
        BRANCH_UNIT = 3'b001,
        MEMORY_UNIT = 3'b010,
        BYPASS_UNIT = 3'b011
    } unit_e;

    ////////////////////
    // Operations
    ////////////////////

    typedef enum logic [`OP_W-1:0] {
        // Arithmetic and logic
        ADD     = 6'b000_000,
        SUB     = 6'b000_001,
        SLT     = 6'b000_010,
        SLTU    = 6'b000_011,
        XOR     = 6'b000_100,
        OR      = 6'b000_101,
        AND     = 6'b000_110,
        // Shifts do not fit in the ALU code, so they get a second one
        SLL     = 6'b100_000,
        SRL     = 6'b100_001,
        SRA     = 6'b100_010,
        // Branch variants follow funct3
        BEQ     = 6'b001_000,
        BNE     = 6'b001_001,
        JAL     = 6'b001_010,
        JALR    = 6'b001_011,
        BLT     = 6'b001_100,
        BGE     = 6'b001_101,
        BLTU    = 6'b001_110,
        BGEU    = 6'b001_111,
        // Loads follow funct3, stores fill the gaps
        LB      = 6'b010_000,
        LH      = 6'b010_001,
        LW      = 6'b010_010,
        SB      = 6'b010_011,
        LBU     = 6'b010_100,
        LHU     = 6'b010_101,
        SH      = 6'b010_110,
        SW      = 6'b010_111,
        // Passed straight through
        NOP     = 6'b011_000,
        LUI     = 6'b011_001,
        INVALID = 6'b011_111
    } op_e;

    ////////////////////
    // Formats
    ////////////////////

    typedef enum logic [2:0] {
        R_TYPE = 3'd0,
        I_TYPE = 3'd1,
        S_TYPE = 3'd2,
        B_TYPE = 3'd3,
        U_TYPE = 3'd4,
        J_TYPE = 3'd5
    } format_e;

    // Same word seen as register fields or as split store/branch immediate
    typedef union packed {
        struct packed {
            logic [`FUNCT7_W-1:0]   funct7;
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [`FUNCT3_W-1:0]   funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [`OPCODE_W-1:0]   opcode;
        } r;
        struct packed {
            logic [`FUNCT7_W-1:0]   imm_hi;    // imm[11:5], imm[12|10:5] on branches
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [`FUNCT3_W-1:0]   funct3;
            logic [`REG_ADDR_W-1:0] imm_lo;    // imm[4:0], imm[4:1|11] on branches
            logic [`OPCODE_W-1:0]   opcode;
        } s;
    } instr_u;

endpackage

/* rtl/op_decoder.sv */
`include "decode_macros.svh"

module op_decoder (
    input  decode_pkg::instr_u  instr_i,
    output decode_pkg::op_e     op_o,
    output decode_pkg::format_e format_o
);

    import decode_pkg::*;

    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT3_W-1:0] funct3;
    logic [`FUNCT7_W-1:0] funct7;

    op_e dec_imm;
    op_e dec_op;
    op_e dec_branch;
    op_e dec_load;
    op_e dec_store;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;

    ////////////////////
    // Group decoders
    ////////////////////

    always_comb begin
        case (funct3)
            3'b000:  dec_imm = ADD;
            3'b010:  dec_imm = SLT;
            3'b011:  dec_imm = SLTU;
            3'b100:  dec_imm = XOR;
            3'b110:  dec_imm = OR;
            3'b111:  dec_imm = AND;
            3'b001:  dec_imm = (funct7 == '0) ? SLL : INVALID;   // shamt upper bits
            3'b101: begin
                if (funct7 == '0)
                    dec_imm = SRL;
                else if (funct7 == `FUNCT7_ALT)
                    dec_imm = SRA;
                else
                    dec_imm = INVALID;
            end
            default: dec_imm = INVALID;
        endcase
    end

    always_comb begin
        if (funct7 == '0) begin
            case (funct3)
                3'b000:  dec_op = ADD;
                3'b001:  dec_op = SLL;
                3'b010:  dec_op = SLT;
                3'b011:  dec_op = SLTU;
                3'b100:  dec_op = XOR;
                3'b101:  dec_op = SRL;
                3'b110:  dec_op = OR;
                default: dec_op = AND;
            endcase
        end else if (funct7 == `FUNCT7_ALT) begin
            case (funct3)
                3'b000:  dec_op = SUB;
                3'b101:  dec_op = SRA;
                default: dec_op = INVALID;
            endcase
        end else begin
            dec_op = INVALID;
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_branch = BEQ;
            3'b001:  dec_branch = BNE;
            3'b100:  dec_branch = BLT;
            3'b101:  dec_branch = BGE;
            3'b110:  dec_branch = BLTU;
            3'b111:  dec_branch = BGEU;
            default: dec_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_load = LB;
            3'b001:  dec_load = LH;
            3'b010:  dec_load = LW;
            3'b100:  dec_load = LBU;
            3'b101:  dec_load = LHU;
            default: dec_load = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_store = SB;
            3'b001:  dec_store = SH;
            3'b010:  dec_store = SW;
            default: dec_store = INVALID;
        endcase
    end

    ////////////////////
    // Opcode select
    ////////////////////

    always_comb begin
        case (opcode)
            `OPC_LUI:      op_o = LUI;
            `OPC_AUIPC:    op_o = ADD;          // PC + upper immediate
            `OPC_JAL:      op_o = JAL;
            `OPC_JALR:     op_o = (funct3 == '0) ? JALR : INVALID;
            `OPC_IMM:      op_o = dec_imm;
            `OPC_OP:       op_o = dec_op;
            `OPC_BRANCH:   op_o = dec_branch;
            `OPC_LOAD:     op_o = dec_load;
            `OPC_STORE:    op_o = dec_store;
            `OPC_MISC_MEM: op_o = (funct3 == '0) ? NOP : INVALID;   // FENCE only
            default:       op_o = INVALID;      // SYSTEM lands here too
        endcase
    end

    always_comb begin
        case (opcode)
            `OPC_IMM, `OPC_JALR, `OPC_LOAD: format_o = I_TYPE;
            `OPC_STORE:                     format_o = S_TYPE;
            `OPC_BRANCH:                    format_o = B_TYPE;
            `OPC_LUI, `OPC_AUIPC:           format_o = U_TYPE;
            `OPC_JAL:                       format_o = J_TYPE;
            default:                        format_o = R_TYPE;
        endcase
    end

endmodule

/* rtl/imm_gen.sv */
`include "decode_macros.svh"

module imm_gen (
    input  decode_pkg::instr_u  instr_i,
    input  decode_pkg::format_e format_i,
    output logic [`XLEN-1:0]    imm_o
);

    import decode_pkg::*;

    logic sign;

    assign sign = instr_i[`SIGN_BIT];

    always_comb begin
        case (format_i)
            I_TYPE: begin
                imm_o = {{20{sign}}, instr_i.r.funct7, instr_i.r.rs2};
            end
            S_TYPE: begin
                imm_o = {{20{sign}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
            end
            // imm[12] is the sign, imm[11] sits in the low field
            B_TYPE: begin
                imm_o = {{19{sign}},
                         sign,
                         instr_i.s.imm_lo[0],
                         instr_i.s.imm_hi[5:0],
                         instr_i.s.imm_lo[4:1],
                         1'b0};
            end
            U_TYPE: begin
                imm_o = {instr_i.r.funct7,
                         instr_i.r.rs2,
                         instr_i.r.rs1,
                         instr_i.r.funct3,
                         12'b0};
            end
            // imm[19:12] is rs1/funct3, imm[11] is rs2 bit 0
            J_TYPE: begin
                imm_o = {{12{sign}},
                         instr_i.r.rs1,
                         instr_i.r.funct3,
                         instr_i.r.rs2[0],
                         instr_i.r.funct7[5:0],
                         instr_i.r.rs2[4:1],
                         1'b0};
            end
            default: begin
                imm_o = '0;     // R format has no immediate
            end
        endcase
    end

endmodule

/* rtl/hazard_control.sv */
`include "decode_macros.svh"

module hazard_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  logic [`XLEN-1:0]        instruction_i,
    input  decode_pkg::op_e         op_i,
    output decode_pkg::instr_u      instr_o,
    output logic [`REG_ADDR_W-1:0]  rs1_o,
    output logic [`REG_ADDR_W-1:0]  rs2_o,
    output logic [`REG_ADDR_W-1:0]  rd_o,
    output logic                    hazard_o
);

    import decode_pkg::*;

    instr_u                  last_instr;
    logic                    last_hazard;
    logic [`REG_ADDR_W-1:0]  lock_reg [2];     // [0] is newest
    logic                    lock_store [2];
    logic [`REG_ADDR_W-1:0]  lock_rd_in;
    logic                    lock_store_in;
    logic                    is_store;
    logic                    writes_rd;
    logic                    mem_op;

    ////////////////////
    // Replay
    ////////////////////

    always_ff @(posedge clk) begin
        last_instr <= instr_o;
        if (reset)
            last_hazard <= 1'b0;
        else
            last_hazard <= hazard_o;
    end

    assign instr_o = last_hazard ? last_instr : instruction_i;   // Redecode after bubble
    assign rs1_o   = instr_o.r.rs1;
    assign rs2_o   = instr_o.r.rs2;
    assign rd_o    = lock_reg[1];

    ////////////////////
    // Lock queue
    ////////////////////

    always_comb begin
        is_store  = op_i inside {SB, SH, SW};
        writes_rd = !is_store && !(op_i inside {BEQ, BNE, BLT, BGE, BLTU, BGEU});
        // A bubble carries no destination and no store
        lock_rd_in    = (hazard_o || !writes_rd) ? '0 : instr_o.r.rd;
        lock_store_in = !hazard_o && is_store;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_reg[0]   <= '0;
            lock_reg[1]   <= '0;
            lock_store[0] <= 1'b0;
            lock_store[1] <= 1'b0;
        end else if (!stall_i) begin
            lock_reg[0]   <= lock_rd_in;
            lock_store[0] <= lock_store_in;
            lock_reg[1]   <= lock_reg[0];
            lock_store[1] <= lock_store[0];
        end
    end

    assign mem_op = unit_e'(op_i[`OP_W-1 -: 3]) == MEMORY_UNIT;

    always_comb begin
        if ((lock_store[0] || lock_store[1]) && mem_op)
            hazard_o = 1'b1;                        // Memory order
        else if (lock_reg[0] == rs1_o && rs1_o != '0)
            hazard_o = 1'b1;
        else if (lock_reg[0] == rs2_o && rs2_o != '0)
            hazard_o = 1'b1;
        else
            hazard_o = 1'b0;
    end

endmodule

/* rtl/operand_stage.sv */
`include "decode_macros.svh"

module operand_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,
    input  logic                hazard_i,
    input  decode_pkg::instr_u  instr_i,
    input  decode_pkg::op_e     op_i,
    input  decode_pkg::format_e format_i,
    input  logic [`XLEN-1:0]    imm_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic [`XLEN-1:0]    rs1_data_i,
    input  logic [`XLEN-1:0]    rs2_data_i,
    output logic [`XLEN-1:0]    first_operand_o,
    output logic [`XLEN-1:0]    second_operand_o,
    output logic [`XLEN-1:0]    third_operand_o,
    output logic [`XLEN-1:0]    pc_o,
    output decode_pkg::op_e     operation_o,
    output logic                exception_o
);

    import decode_pkg::*;

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] first_operand;
    logic [`XLEN-1:0] second_operand;
    logic [`XLEN-1:0] third_operand;

    ////////////////////
    // Operand select
    ////////////////////

    // x0 always reads as zero
    assign rs1_val = (instr_i.r.rs1 == '0) ? '0 : rs1_data_i;
    assign rs2_val = (instr_i.r.rs2 == '0) ? '0 : rs2_data_i;

    always_comb begin
        first_operand  = (format_i == U_TYPE || format_i == J_TYPE) ? pc_i : rs1_val;
        second_operand = (format_i == R_TYPE || format_i == B_TYPE) ? rs2_val : imm_i;
        third_operand  = (format_i == S_TYPE) ? rs2_val : imm_i;   // Store data
    end

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            operation_o      <= NOP;
            exception_o      <= 1'b0;
        end else if (stall_i) begin
            // Hold everything
        end else if (hazard_i) begin
            first_operand_o  <= '0;            // Bubble
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            operation_o      <= NOP;
            exception_o      <= 1'b0;
        end else begin
            first_operand_o  <= first_operand;
            second_operand_o <= second_operand;
            third_operand_o  <= third_operand;
            pc_o             <= pc_i;
            operation_o      <= op_i;
            exception_o      <= (op_i == INVALID);
        end
    end

endmodule

/* rtl/decode_stage.sv */
`include "decode_macros.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  logic [`XLEN-1:0]        instruction_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`XLEN-1:0]        rs1_data_i,      // From register bank
    input  logic [`XLEN-1:0]        rs2_data_i,
    output logic [`REG_ADDR_W-1:0]  rs1_o,           // To register bank
    output logic [`REG_ADDR_W-1:0]  rs2_o,
    output logic [`REG_ADDR_W-1:0]  rd_o,
    output logic [`XLEN-1:0]        first_operand_o,
    output logic [`XLEN-1:0]        second_operand_o,
    output logic [`XLEN-1:0]        third_operand_o,
    output logic [`XLEN-1:0]        pc_o,
    output decode_pkg::op_e         operation_o,
    output logic                    hazard_o,
    output logic                    exception_o
);

    import decode_pkg::*;

    instr_u           instr;       // Live or replayed word
    op_e              op;
    format_e          format;
    logic [`XLEN-1:0] imm;

    hazard_control u_hazard_control (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .op_i          (op),
        .instr_o       (instr),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rd_o          (rd_o),
        .hazard_o      (hazard_o)
    );

    op_decoder u_op_decoder (
        .instr_i  (instr),
        .op_o     (op),
        .format_o (format)
    );

    imm_gen u_imm_gen (
        .instr_i  (instr),
        .format_i (format),
        .imm_o    (imm)
    );

    operand_stage u_operand_stage (
        .clk              (clk),
        .reset            (reset),
        .stall_i          (stall_i),
        .hazard_i         (hazard_o),
        .instr_i          (instr),
        .op_i             (op),
        .format_i         (format),
        .imm_i            (imm),
        .pc_i             (pc_i),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .first_operand_o  (first_operand_o),
        .second_operand_o (second_operand_o),
        .third_operand_o  (third_operand_o),
        .pc_o             (pc_o),
        .operation_o      (operation_o),
        .exception_o      (exception_o)
    );

endmodule

/* tests/decode_stage_checker.sv */
`include "decode_macros.svh"

module decode_stage_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  logic                    hazard_o,
    input  decode_pkg::op_e         operation_o,
    input  logic                    exception_o,
    input  logic [`REG_ADDR_W-1:0]  rd_o,
    input  logic [`XLEN-1:0]        first_operand_o,
    input  logic [`XLEN-1:0]        second_operand_o,
    input  logic [`XLEN-1:0]        third_operand_o,
    input  logic [`XLEN-1:0]        pc_o
);

    import decode_pkg::*;

    logic outputs_zero;

    assign outputs_zero = first_operand_o == '0 && second_operand_o == '0 &&
                          third_operand_o == '0 && pc_o == '0;

    // Output registers come out of reset empty
    reset_clears_outputs: assert property (
        @(posedge clk) reset |=> operation_o == NOP && !exception_o && outputs_zero)
        else $error("output registers not cleared by reset");

    hazard_gives_bubble: assert property (
        @(posedge clk) disable iff (reset)
        hazard_o && !stall_i |=> operation_o == NOP && !exception_o && outputs_zero)
        else $error("hazard did not produce a NOP bubble");

    // Lock queue holds too, so rd_o must not move
    stall_holds_outputs: assert property (
        @(posedge clk) disable iff (reset)
        stall_i |=> $stable({operation_o, exception_o, rd_o, first_operand_o,
                             second_operand_o, third_operand_o, pc_o}))
        else $error("outputs changed while stalled");

endmodule

bind decode_stage decode_stage_checker u_checker (
    .clk              (clk),
    .reset            (reset),
    .stall_i          (stall_i),
    .hazard_o         (hazard_o),
    .operation_o      (operation_o),
    .exception_o      (exception_o),
    .rd_o             (rd_o),
    .first_operand_o  (first_operand_o),
    .second_operand_o (second_operand_o),
    .third_operand_o  (third_operand_o),
    .pc_o             (pc_o)
);

/* tests/decode_stage_tb.sv */
`include "decode_macros.svh"

module decode_stage_tb;

    import decode_pkg::*;

    localparam int WAIT_LIMIT = 10;    // Cycles before a result counts as lost

    logic                   clk;
    logic                   reset;
    logic                   stall_i;
    logic [`XLEN-1:0]       instruction_i;
    logic [`XLEN-1:0]       pc_i;
    logic [`XLEN-1:0]       rs1_data_i;
    logic [`XLEN-1:0]       rs2_data_i;
    logic [`REG_ADDR_W-1:0] rs1_o;
    logic [`REG_ADDR_W-1:0] rs2_o;
    logic [`REG_ADDR_W-1:0] rd_o;
    logic [`XLEN-1:0]       first_operand_o;
    logic [`XLEN-1:0]       second_operand_o;
    logic [`XLEN-1:0]       third_operand_o;
    logic [`XLEN-1:0]       pc_o;
    op_e                    operation_o;
    logic                   hazard_o;
    logic                   exception_o;

    int errors;
    int tests_failed;
    int hazard_cycles;

    // Stimulus table, one column per queue
    string                  t_name[$];
    logic [`XLEN-1:0]       t_instr[$];
    logic [`XLEN-1:0]       t_pc[$];
    op_e                    t_op[$];
    logic [`XLEN-1:0]       t_first[$];
    logic [`XLEN-1:0]       t_second[$];
    logic [`XLEN-1:0]       t_third[$];
    logic                   t_exc[$];
    logic [`REG_ADDR_W-1:0] t_rd[$];        // Destination locked by the entry, 0 if none
    int                     t_bubbles[$];
    int                     t_stall[$];      // Stall cycles before the entry is accepted

    decode_stage UUT (
        .clk              (clk),
        .reset            (reset),
        .stall_i          (stall_i),
        .instruction_i    (instruction_i),
        .pc_i             (pc_i),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .rs1_o            (rs1_o),
        .rs2_o            (rs2_o),
        .rd_o             (rd_o),
        .first_operand_o  (first_operand_o),
        .second_operand_o (second_operand_o),
        .third_operand_o  (third_operand_o),
        .pc_o             (pc_o),
        .operation_o      (operation_o),
        .hazard_o         (hazard_o),
        .exception_o      (exception_o)
    );

    ////////////////////
    // Register bank model
    ////////////////////

    function automatic logic [`XLEN-1:0] bank(input logic [`REG_ADDR_W-1:0] addr);
        return 32'h01010101 * addr;
    endfunction

    assign rs1_data_i = bank(rs1_o);
    assign rs2_data_i = bank(rs2_o);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Hazard seen at an accepting edge
    always @(posedge clk) begin
        if (!reset && !stall_i && hazard_o)
            hazard_cycles++;
    end

    task automatic add_test(input string name, input logic [`XLEN-1:0] instr,
                            input logic [`XLEN-1:0] pc, input op_e op,
                            input logic [`XLEN-1:0] first, input logic [`XLEN-1:0] second,
                            input logic [`XLEN-1:0] third, input logic exc,
                            input logic [`REG_ADDR_W-1:0] rd, input int bubbles,
                            input int stall);
        t_name.push_back(name);
        t_instr.push_back(instr);
        t_pc.push_back(pc);
        t_op.push_back(op);
        t_first.push_back(first);
        t_second.push_back(second);
        t_third.push_back(third);
        t_exc.push_back(exc);
        t_rd.push_back(rd);
        t_bubbles.push_back(bubbles);
        t_stall.push_back(stall);
    endtask

    task automatic check_value(input string what, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_outputs(input string name, input op_e op,
                                 input logic [`XLEN-1:0] first,
                                 input logic [`XLEN-1:0] second,
                                 input logic [`XLEN-1:0] third,
                                 input logic [`XLEN-1:0] pc,
                                 input logic exc);
        check_value({name, " operation"}, op, operation_o);
        check_value({name, " exception"}, exc, exception_o);
        check_value({name, " first operand"}, first, first_operand_o);
        check_value({name, " second operand"}, second, second_operand_o);
        check_value({name, " third operand"}, third, third_operand_o);
        check_value({name, " pc"}, pc, pc_o);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d mismatches", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    ////////////////////
    // Apply one entry
    ////////////////////

    task automatic apply_test(input int i);
        int errors_before;
        int waited;
        int bubbles;
        int k;
        logic [`REG_ADDR_W-1:0] prev_rd;
        errors_before = errors;
        hazard_cycles = 0;
        instruction_i = t_instr[i];
        pc_i          = t_pc[i];
        if (t_stall[i] > 0) begin
            stall_i = 1'b1;
            for (k = 0; k < t_stall[i]; k++) begin
                @(negedge clk);
                // Previous entry's result must stay put
                check_outputs({t_name[i], " during stall"}, t_op[i-1], t_first[i-1],
                              t_second[i-1], t_third[i-1], t_pc[i-1], t_exc[i-1]);
            end
            stall_i = 1'b0;
        end
        waited  = 0;
        bubbles = 0;
        @(negedge clk);
        while (operation_o == NOP && waited < WAIT_LIMIT) begin
            bubbles++;
            waited++;
            @(negedge clk);
        end
        if (operation_o == NOP) begin
            $display("test %s gave no result within %0d cycles", t_name[i], WAIT_LIMIT);
            errors++;
        end else begin
            check_outputs(t_name[i], t_op[i], t_first[i], t_second[i], t_third[i], t_pc[i],
                          t_exc[i]);
            check_value({t_name[i], " bubbles"}, t_bubbles[i], bubbles);
            check_value({t_name[i], " hazard cycles"}, t_bubbles[i], hazard_cycles);
            // rd_o trails by two slots, the one before the result
            if (t_bubbles[i] > 0 || i == 0)
                prev_rd = '0;
            else
                prev_rd = t_rd[i-1];
            check_value({t_name[i], " rd"}, prev_rd, rd_o);
        end
        report_test(t_name[i], errors_before);
    endtask

    initial begin
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = 32'h0000000F;    // FENCE, decodes as NOP
        pc_i          = '0;
        errors        = 0;
        tests_failed  = 0;
        hazard_cycles = 0;

        add_test("add", 32'h002081B3, 'h100, ADD, bank(1), bank(2), 0, 0, 3, 0, 0);
        add_test("sub", 32'h40628233, 'h104, SUB, bank(5), bank(6), 0, 0, 4, 0, 0);
        add_test("sra", 32'h409453B3, 'h108, SRA, bank(8), bank(9), 0, 0, 7, 0, 0);
        add_test("slti_negative", 32'hFFB5A513, 'h10C, SLT, bank(11), -5, -5, 0, 10, 0, 0);
        add_test("slli", 32'h00469613, 'h110, SLL, bank(13), 4, 4, 0, 12, 0, 0);
        add_test("sw_negative", 32'hFEE7AC23, 'h114, SW, bank(15), -8, bank(14), 0, 0, 0, 0);
        // Store sits in both lock entries in turn
        add_test("lw_after_sw", 32'h0048A803, 'h118, LW, bank(17), 4, 4, 0, 16, 2, 0);
        add_test("addi", 32'h12308913, 'h11C, ADD, bank(1), 'h123, 'h123, 0, 18, 0, 0);
        add_test("add_after_addi", 32'h002909B3, 'h120, ADD, bank(18), bank(2), 0, 0, 19, 1, 0);
        add_test("beq", 32'hFF5A08E3, 'h124, BEQ, bank(20), bank(21), -16, 0, 0, 0, 0);
        add_test("jal", 32'h02401B6F, 'h200, JAL, 'h200, 'h1024, 'h1024, 0, 22, 0, 0);
        add_test("lui", 32'hABCDEBB7, 'h300, LUI, 'h300, 'hABCDE000, 'hABCDE000, 0, 23, 0, 0);
        add_test("auipc", 32'h00012C17, 'h400, ADD, 'h400, 'h12000, 'h12000, 0, 24, 0, 0);
        add_test("bad_opcode", 32'h0000007F, 'h404, INVALID, 0, 0, 0, 1, 0, 0, 0);
        add_test("system", 32'h00000073, 'h408, INVALID, 0, 0, 0, 1, 0, 0, 0);
        add_test("bad_funct7", 32'h02208D33, 'h40C, INVALID, bank(1), bank(2), 0, 1, 26, 0, 0);
        add_test("or_stalled", 32'h0041EDB3, 'h410, OR, bank(3), bank(4), 0, 0, 27, 0, 3);

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_outputs("reset", NOP, '0, '0, '0, '0, 1'b0);
        check_value("reset rd", '0, rd_o);
        report_test("reset", 0);

        foreach (t_name[i]) begin
            apply_test(i);
        end

        $display("%0d tests, %0d passed, %0d failed", t_name.size() + 1,
                 t_name.size() + 1 - tests_failed, tests_failed);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* decode_stage.f */
+incdir+rtl
rtl/decode_pkg.sv
rtl/op_decoder.sv
rtl/imm_gen.sv
rtl/hazard_control.sv
rtl/operand_stage.sv
rtl/decode_stage.sv
tests/decode_stage_checker.sv
tests/decode_stage_tb.sv
